// File: src.f
source/ahbApbPkg.sv
source/ahbTransferCapture.sv
source/apbBridgeFsm.sv
source/byteLaneSteer.sv
source/ahbApbBridge.sv
sim/apbSlaveModel.sv
sim/tbBridge.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the AHB to APB bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tbBridge -Mdir obj_dir -o simBridge
./obj_dir/simBridge 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// File: sim/tbBridge.sv
`timescale 1ns/1ps
/* AHB to APB bridge testbench
   Directed AHB transfers against a four-slave APB memory model */
module tbBridge import ahbApbPkg::*;
();

	localparam logic [31:0] LcgSeed           = 32'h9ef777e8;
	localparam logic [1:0]  HtransIdle        = 2'b00;
	localparam int          ResetCycles       = 8;
	localparam int          PlannedTransfers  = 27;
	localparam int          CyclesPerTransfer = 200;

	logic                 Hclk;
	logic                 Hresetn;
	logic                 Hsel;
	logic [AddrWidth-1:0] Haddr;
	logic                 Hwrite;
	logic [1:0]           Htrans;
	logic [2:0]           Hsize;
	logic [DataWidth-1:0] Hwdata;
	logic                 Hready;
	logic                 Hreadyout;
	logic [DataWidth-1:0] Hrdata;
	logic [NumSlaves-1:0] Psel;
	logic                 Penable;
	logic                 Pwrite;
	logic [AddrWidth-1:0] Paddr;
	logic [DataWidth-1:0] Pwdata;
	logic [DataWidth-1:0] Prdata;
	logic [NumSlaves-1:0] lastPsel;
	logic [DataWidth-1:0] lastWdata [NumSlaves];
	logic [AddrWidth-1:0] lastAddr [NumSlaves];
	logic [DataWidth-1:0] expMem [NumSlaves][16]; // Expected slave contents
	logic [31:0]          lcgState;
	int                   errorCount;

	assign Hready = Hreadyout; // Single slave on the bus

	ahbApbBridge u_ahbApbBridge
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hsel(Hsel),
		.Haddr(Haddr),
		.Hwrite(Hwrite),
		.Htrans(Htrans),
		.Hsize(Hsize),
		.Hwdata(Hwdata),
		.Hready(Hready),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.Psel(Psel),
		.Penable(Penable),
		.Pwrite(Pwrite),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Prdata(Prdata)
	);

	apbSlaveModel u_apbSlaveModel
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Psel(Psel),
		.Penable(Penable),
		.Pwrite(Pwrite),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Prdata(Prdata),
		.lastPsel(lastPsel),
		.lastWdata(lastWdata),
		.lastAddr(lastAddr)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #5 Hclk = ~Hclk;
	end

	initial
	begin
		repeat (ResetCycles + PlannedTransfers * CyclesPerTransfer) @(posedge Hclk);
		$display("timeout: the directed tests did not complete in time");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Same power-up contents as the slave model
	function automatic logic [31:0] defaultWord(input logic [1:0] slave, input logic [3:0] word);
		logic [31:0] addr;

		addr = {16'h0000, 2'b00, slave, 6'b000000, word, 2'b00};
		return 32'h5a3c_0000 ^ {addr[15:0], ~addr[15:0]};
	endfunction

	function automatic logic [31:0] slaveAddr(input logic [1:0] slave, input logic [3:0] word,
		input logic [1:0] offset);
		return {16'h0000, 2'b00, slave, 6'b000000, word, offset};
	endfunction

	function automatic logic [NumSlaves-1:0] expectedSel(input logic [31:0] addr);
		logic [NumSlaves-1:0] sel;

		sel = '0;
		if ((addr[31:16] == 16'h0000) && (addr[15:12] < 4'(NumSlaves)))
			sel[addr[13:12]] = 1'b1;
		return sel;
	endfunction

	// Addressed lane shifted down to bit 0, zero when misaligned
	function automatic logic [31:0] laneOf(input logic [2:0] size, input logic [1:0] offset,
		input logic [31:0] data);
		logic [31:0] shifted;

		shifted = data >> (8 * offset);
		case (size)
			SizeByte: return shifted & 32'h0000_00ff;
			SizeHalf: return offset[0] ? 32'd0 : (shifted & 32'h0000_ffff);
			SizeWord: return (offset == 2'b00) ? data : 32'd0;
			default:  return 32'd0;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic checkTrue(input logic condition, input string what);
		assert (condition === 1'b1)
		else
		begin
			errorCount++;
			$display("error at %0t ns: %s", $time, what);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(negedge Hclk);
	endtask

	// Returns in WriteEnable, where a next transfer may be issued
	task automatic writeTransfer(input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] data);
		logic [NumSlaves-1:0] sel;
		logic [31:0]          lane;

		sel  = expectedSel(addr);
		lane = laneOf(size, addr[1:0], data);
		checkTrue(Hreadyout, "bridge not ready when a write was issued");
		Hsel   = 1'b1;
		Haddr  = addr;
		Hwrite = 1'b1;
		Htrans = HtransNonseq;
		Hsize  = size;
		@(negedge Hclk); // WriteWait
		Hsel   = 1'b0;
		Htrans = HtransIdle;
		Hwdata = data;
		checkValue("Hreadyout", 32'(Hreadyout), 32'd0);
		checkValue("Psel", 32'(Psel), 32'd0);
		checkValue("Penable", 32'(Penable), 32'd0);
		@(negedge Hclk); // WriteSetup
		checkValue("Psel", 32'(Psel), 32'(sel));
		checkValue("Pwrite", 32'(Pwrite), 32'd1);
		checkValue("Penable", 32'(Penable), 32'd0);
		checkValue("Hreadyout", 32'(Hreadyout), 32'd0);
		checkValue("Paddr", Paddr, addr);
		checkValue("Pwdata", Pwdata, lane);
		@(negedge Hclk); // WriteEnable
		checkValue("Psel", 32'(Psel), 32'(sel));
		checkValue("Penable", 32'(Penable), 32'd1);
		checkValue("Hreadyout", 32'(Hreadyout), 32'd1);
		if (|sel)
			expMem[addr[13:12]][addr[5:2]] = lane;
	endtask

	task automatic readTransfer(input logic [31:0] addr, input logic [2:0] size);
		logic [NumSlaves-1:0] sel;
		logic [31:0]          expected;

		sel      = expectedSel(addr);
		expected = (|sel) ? laneOf(size, addr[1:0], expMem[addr[13:12]][addr[5:2]]) : 32'd0;
		checkTrue(Hreadyout, "bridge not ready when a read was issued");
		Hsel   = 1'b1;
		Haddr  = addr;
		Hwrite = 1'b0;
		Htrans = HtransNonseq;
		Hsize  = size;
		@(negedge Hclk); // ReadSetup
		Hsel   = 1'b0;
		Htrans = HtransIdle;
		checkValue("Psel", 32'(Psel), 32'(sel));
		checkValue("Penable", 32'(Penable), 32'd0);
		checkValue("Pwrite", 32'(Pwrite), 32'd0);
		checkValue("Hreadyout", 32'(Hreadyout), 32'd0);
		@(negedge Hclk); // ReadEnable
		checkValue("Psel", 32'(Psel), 32'(sel));
		checkValue("Penable", 32'(Penable), 32'd1);
		checkValue("Hreadyout", 32'(Hreadyout), 32'd1);
		checkValue("Hrdata", Hrdata, expected);
	endtask

	task automatic checkRecorded(input logic [1:0] slave, input logic [31:0] addr,
		input logic [31:0] data);
		logic [NumSlaves-1:0] sel;

		sel        = '0;
		sel[slave] = 1'b1;
		checkValue("lastPsel", 32'(lastPsel), 32'(sel));
		checkValue("lastWdata", lastWdata[slave], data);
		checkValue("lastAddr", lastAddr[slave], addr);
	endtask

	task automatic testReset();
		checkValue("Psel", 32'(Psel), 32'd0);
		checkValue("Penable", 32'(Penable), 32'd0);
		checkValue("Pwrite", 32'(Pwrite), 32'd0);
		checkValue("Hreadyout", 32'(Hreadyout), 32'd1);
	endtask

	task automatic testWordPerSlave();
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] data;

		for (int s = 0; s < NumSlaves; s++)
		begin
			rnd  = nextRand();
			addr = slaveAddr(2'(s), rnd[19:16], 2'b00);
			data = nextRand();
			writeTransfer(addr, SizeWord, data);
			idleCycles(1);
			checkRecorded(2'(s), addr, data);
			readTransfer(addr, SizeWord);
			idleCycles(1);
		end
	endtask

	task automatic testNarrowWrites();
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] data;

		rnd = nextRand();
		for (int off = 0; off < 4; off++)
		begin
			addr = slaveAddr(rnd[21:20], rnd[19:16], 2'(off));
			data = nextRand();
			writeTransfer(addr, SizeByte, data);
			idleCycles(1);
			checkRecorded(rnd[21:20], addr, laneOf(SizeByte, 2'(off), data));
		end
		for (int off = 0; off < 4; off += 2)
		begin
			addr = slaveAddr(rnd[21:20], rnd[19:16], 2'(off));
			data = nextRand();
			writeTransfer(addr, SizeHalf, data);
			idleCycles(1);
			checkRecorded(rnd[21:20], addr, laneOf(SizeHalf, 2'(off), data));
		end
		addr = slaveAddr(rnd[21:20], rnd[19:16], 2'b01); // Misaligned halfword
		writeTransfer(addr, SizeHalf, nextRand());
		idleCycles(1);
		checkRecorded(rnd[21:20], addr, 32'd0);
	endtask

	task automatic testNarrowReads();
		logic [31:0] rnd;

		rnd = nextRand();
		writeTransfer(slaveAddr(rnd[21:20], rnd[19:16], 2'b00), SizeWord, nextRand());
		idleCycles(1);
		for (int off = 0; off < 4; off++)
			readTransfer(slaveAddr(rnd[21:20], rnd[19:16], 2'(off)), SizeByte);
		for (int off = 0; off < 4; off += 2)
			readTransfer(slaveAddr(rnd[21:20], rnd[19:16], 2'(off)), SizeHalf);
		idleCycles(1);
	endtask

	task automatic testUnmapped();
		logic [31:0]          rnd;
		logic [31:0]          low;
		logic [31:0]          addr;
		logic [NumSlaves-1:0] prevSel;

		rnd     = nextRand();
		low     = slaveAddr(rnd[5:4], rnd[3:0], 2'b00);
		addr    = {rnd[31:16] | 16'h0001, low[15:0]};
		prevSel = lastPsel;
		writeTransfer(addr, SizeWord, nextRand());
		idleCycles(1);
		checkValue("lastPsel", 32'(lastPsel), 32'(prevSel));
		readTransfer(addr, SizeWord);
		idleCycles(1);
		readTransfer(low, SizeWord); // Mapped alias keeps its contents
		idleCycles(1);
	endtask

	task automatic testBackToBack();
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] data;

		rnd  = nextRand();
		addr = slaveAddr(rnd[21:20], rnd[19:16], 2'b00);
		data = nextRand();
		writeTransfer(addr, SizeWord, data);
		checkValue("Pwrite", 32'(Pwrite), 32'd1); // Read issued in WriteEnable
		readTransfer(addr, SizeWord);
		idleCycles(1);
		checkRecorded(rnd[21:20], addr, data);
	endtask

	initial
	begin
		errorCount = 0;
		lcgState   = LcgSeed;
		Hresetn    = 1'b0;
		Hsel       = 1'b0;
		Haddr      = '0;
		Hwrite     = 1'b0;
		Htrans     = HtransIdle;
		Hsize      = SizeWord;
		Hwdata     = '0;
		for (int s = 0; s < NumSlaves; s++)
		begin
			for (int w = 0; w < 16; w++)
				expMem[s][w] = defaultWord(2'(s), 4'(w));
		end
		repeat (ResetCycles) @(negedge Hclk);
		Hresetn = 1'b1;
		testReset();
		idleCycles(1);
		testWordPerSlave();
		testNarrowWrites();
		testNarrowReads();
		testUnmapped();
		testBackToBack();
		if (errorCount == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
		begin
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

// File: sim/apbSlaveModel.sv
`timescale 1ns/1ps
/* APB slave memory model
   Four 16-word slaves with zero wait states, records the last write per slave */
module apbSlaveModel import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic [NumSlaves-1:0] Psel,
	input  logic                 Penable,
	input  logic                 Pwrite,
	input  logic [AddrWidth-1:0] Paddr,
	input  logic [DataWidth-1:0] Pwdata,
	output logic [DataWidth-1:0] Prdata,
	output logic [NumSlaves-1:0] lastPsel,
	output logic [DataWidth-1:0] lastWdata [NumSlaves],
	output logic [AddrWidth-1:0] lastAddr [NumSlaves]
);

	logic [DataWidth-1:0] mem [NumSlaves][16];

	// Power-up contents built from slave index and word address
	function automatic logic [DataWidth-1:0] fillPattern(input logic [1:0] slave,
		input logic [3:0] word);
		logic [AddrWidth-1:0] addr;

		addr = {16'h0000, 2'b00, slave, 6'b000000, word, 2'b00};
		return 32'h5a3c_0000 ^ {addr[15:0], ~addr[15:0]};
	endfunction

	always_comb
	begin
		Prdata = '0;
		for (int i = 0; i < NumSlaves; i++)
		begin
			if (Psel[i])
				Prdata = Prdata | mem[i][Paddr[5:2]];
		end
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			lastPsel <= '0;
			for (int i = 0; i < NumSlaves; i++)
			begin
				lastWdata[i] <= '0;
				lastAddr[i]  <= '0;
				for (int w = 0; w < 16; w++)
					mem[i][w] <= fillPattern(2'(i), 4'(w));
			end
		end
		else if (Penable && Pwrite && (|Psel))
		begin
			lastPsel <= Psel; // Whole select vector of the write
			for (int i = 0; i < NumSlaves; i++)
			begin
				if (Psel[i])
				begin
					mem[i][Paddr[5:2]] <= Pwdata;
					lastWdata[i]       <= Pwdata;
					lastAddr[i]        <= Paddr;
				end
			end
		end
	end

endmodule

// File: source/ahbApbBridge.sv
`timescale 1ns/1ps
/* AHB to APB bridge top level
   One AHB slave port in front of four APB slaves */
module ahbApbBridge import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 Hsel,
	input  logic [AddrWidth-1:0] Haddr,
	input  logic                 Hwrite,
	input  logic [1:0]           Htrans,
	input  logic [2:0]           Hsize,
	input  logic [DataWidth-1:0] Hwdata,
	input  logic                 Hready,
	output logic                 Hreadyout,
	output logic [DataWidth-1:0] Hrdata,
	output logic [NumSlaves-1:0] Psel,
	output logic                 Penable,
	output logic                 Pwrite,
	output logic [AddrWidth-1:0] Paddr,
	output logic [DataWidth-1:0] Pwdata,
	input  logic [DataWidth-1:0] Prdata
);

	logic                 transferValid;
	logic                 xferWrite;
	transferSize          xferSize;
	logic [NumSlaves-1:0] slaveSel;
	logic [DataWidth-1:0] wdataHold;
	logic                 captureWdata;
	logic [DataWidth-1:0] readLane;

	ahbTransferCapture u_ahbTransferCapture
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hsel(Hsel),
		.Haddr(Haddr),
		.Hwrite(Hwrite),
		.Htrans(Htrans),
		.Hsize(Hsize),
		.Hwdata(Hwdata),
		.Hready(Hready),
		.Hreadyout(Hreadyout),
		.captureWdata(captureWdata),
		.transferValid(transferValid),
		.Paddr(Paddr),
		.xferWrite(xferWrite),
		.xferSize(xferSize),
		.slaveSel(slaveSel),
		.wdataHold(wdataHold)
	);

	apbBridgeFsm u_apbBridgeFsm
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.transferValid(transferValid),
		.xferWrite(xferWrite),
		.slaveSel(slaveSel),
		.Psel(Psel),
		.Penable(Penable),
		.Pwrite(Pwrite),
		.Hreadyout(Hreadyout),
		.captureWdata(captureWdata)
	);

	byteLaneSteer u_byteLaneSteer
	(
		.xferSize(xferSize),
		.addrOffset(Paddr[1:0]),
		.wdataHold(wdataHold),
		.Prdata(Prdata),
		.Pwdata(Pwdata),
		.Hrdata(readLane)
	);

	// Read data only in the read enable phase
	assign Hrdata = (Penable && !Pwrite) ? readLane : '0;

endmodule

// File: source/byteLaneSteer.sv
`timescale 1ns/1ps
/* Little-endian byte lane steering
   Right-aligns the addressed lane of write and read data by size and offset */
module byteLaneSteer import ahbApbPkg::*;
(
	input  transferSize          xferSize,
	input  logic [1:0]           addrOffset,
	input  logic [DataWidth-1:0] wdataHold,
	input  logic [DataWidth-1:0] Prdata,
	output logic [DataWidth-1:0] Pwdata,
	output logic [DataWidth-1:0] Hrdata
);

	function automatic logic [DataWidth-1:0] laneSelect
	(
		input transferSize          size,
		input logic [1:0]           offset,
		input logic [DataWidth-1:0] data
	);
		logic [DataWidth-1:0] lane;

		lane = '0;
		case (size)
			SizeByte:
				lane[7:0] = data[{offset, 3'b000} +: 8];
			SizeHalf:
			begin
				if (!offset[0])
					lane[15:0] = data[{offset[1], 4'b0000} +: 16]; // Lower or upper half
			end
			SizeWord:
			begin
				if (offset == 2'b00)
					lane = data;
			end
			default:
				lane = '0;
		endcase
		return lane;
	endfunction

	// Same rule both ways
	assign Pwdata = laneSelect(xferSize, addrOffset, wdataHold);
	assign Hrdata = laneSelect(xferSize, addrOffset, Prdata);

endmodule

// File: source/apbBridgeFsm.sv
`timescale 1ns/1ps
/* APB phase sequencer
   Steps each accepted transfer through setup and enable, drives the strobes and Hreadyout */
module apbBridgeFsm import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 transferValid,
	input  logic                 xferWrite,
	input  logic [NumSlaves-1:0] slaveSel,
	output logic [NumSlaves-1:0] Psel,
	output logic                 Penable,
	output logic                 Pwrite,
	output logic                 Hreadyout,
	output logic                 captureWdata
);

	bridgeState state;
	bridgeState nextState;
	logic       readyNext;

	always_comb
	begin
		nextState = state;
		case (state)
			Idle:
			begin
				if (transferValid)
					nextState = xferWrite ? WriteWait : ReadSetup;
			end
			ReadSetup:
				nextState = ReadEnable;
			WriteWait:
				nextState = WriteSetup;
			WriteSetup:
				nextState = WriteEnable;
			ReadEnable, WriteEnable:
			begin
				// Next address phase overlaps the enable phase
				if (transferValid)
					nextState = xferWrite ? WriteWait : ReadSetup;
				else
					nextState = Idle;
			end
			default:
				nextState = Idle;
		endcase
	end

	// Data phase stalls until the APB enable phase
	assign readyNext = !(nextState inside {ReadSetup, WriteWait, WriteSetup});

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			state     <= Idle;
			Hreadyout <= 1'b1;
		end
		else
		begin
			state     <= nextState;
			Hreadyout <= readyNext;
		end
	end

	always_comb
	begin
		Psel    = '0;
		Penable = 1'b0;
		Pwrite  = 1'b0;
		case (state)
			ReadSetup:
				Psel = slaveSel;
			ReadEnable:
			begin
				Psel    = slaveSel;
				Penable = 1'b1;
			end
			WriteSetup:
			begin
				Psel   = slaveSel;
				Pwrite = 1'b1;
			end
			WriteEnable:
			begin
				Psel    = slaveSel;
				Penable = 1'b1;
				Pwrite  = 1'b1;
			end
			default:
				Psel = '0; // Idle and WriteWait keep the APB bus quiet
		endcase
	end

	assign captureWdata = (state == WriteWait);

	// Enable phase keeps the slave and direction of its setup phase
	aEnableSelected: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> (Psel == $past(Psel)) && (Pwrite == $past(Pwrite)));

	// Every enable phase lasts one cycle
	aEnableSingle: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |=> !Penable);

endmodule

// File: source/ahbTransferCapture.sv
`timescale 1ns/1ps
/* AHB transfer capture
   Qualifies address phases, holds the transfer attributes and write data, decodes the slave */
module ahbTransferCapture import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 Hsel,
	input  logic [AddrWidth-1:0] Haddr,
	input  logic                 Hwrite,
	input  logic [1:0]           Htrans,
	input  logic [2:0]           Hsize,
	input  logic [DataWidth-1:0] Hwdata,
	input  logic                 Hready,
	input  logic                 Hreadyout,
	input  logic                 captureWdata,
	output logic                 transferValid,
	output logic [AddrWidth-1:0] Paddr,
	output logic                 xferWrite,
	output transferSize          xferSize,
	output logic [NumSlaves-1:0] slaveSel,
	output logic [DataWidth-1:0] wdataHold
);

	logic                             htransActive;
	logic                             regionHit;
	logic [SlaveSelMsb-SlaveSelLsb:0] slaveIdx;
	logic [NumSlaves-1:0]             decodeSel;
	logic                             xferWriteReg;

	assign htransActive  = (Htrans == HtransNonseq) || (Htrans == HtransSeq);
	assign transferValid = Hsel && htransActive && Hready && Hreadyout;

	// Address map decode
	assign regionHit = (Haddr[AddrWidth-1:SlaveSelMsb+1] == SlaveRegionBase);
	assign slaveIdx  = Haddr[SlaveSelMsb:SlaveSelLsb];

	always_comb
	begin
		for (int i = 0; i < NumSlaves; i++)
		begin
			decodeSel[i] = regionHit && (slaveIdx == ($bits(slaveIdx))'(i)); // Index above range stays unmapped
		end
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			Paddr        <= '0;
			xferWriteReg <= 1'b0;
			xferSize     <= SizeByte;
			slaveSel     <= '0;
		end
		else if (transferValid)
		begin
			Paddr        <= Haddr;
			xferWriteReg <= Hwrite;
			xferSize     <= transferSize'(Hsize);
			slaveSel     <= decodeSel;
		end
	end

	// FSM picks the direction in the accepting cycle
	assign xferWrite = transferValid ? Hwrite : xferWriteReg;

	always_ff @(posedge Hclk)
	begin
		if (captureWdata)
			wdataHold <= Hwdata; // End of the write data phase
	end

	aSizeLegal: assert property (@(posedge Hclk) disable iff (!Hresetn)
		transferValid |-> (Hsize <= SizeWord));

endmodule

// File: source/ahbApbPkg.sv
/* AHB to APB bridge shared definitions
   Bus widths, slave address map, FSM states and AHB transfer sizes */
package ahbApbPkg;

	localparam int AddrWidth = 32;
	localparam int DataWidth = 32;

	localparam int NumSlaves = 4;

	// Slave index field, one 4 KB region per slave
	localparam int SlaveSelMsb = 15;
	localparam int SlaveSelLsb = 12;

	// Upper address bits required for a mapped transfer
	localparam logic [AddrWidth-SlaveSelMsb-2:0] SlaveRegionBase = '0;

	// Htrans codes of an active transfer
	localparam logic [1:0] HtransNonseq = 2'b10;
	localparam logic [1:0] HtransSeq    = 2'b11;

	typedef enum logic [2:0]
	{
		Idle,
		ReadSetup,
		ReadEnable,
		WriteWait,   // Waiting for Hwdata in the AHB data phase
		WriteSetup,
		WriteEnable
	} bridgeState;

	typedef enum logic [2:0]
	{
		SizeByte = 3'b000,
		SizeHalf = 3'b001,
		SizeWord = 3'b010
	} transferSize;

endpackage
